// File: files.f
+incdir+source
source/uart_dma_pkg.sv
source/uart_byte_rx.sv
source/host_cmd_decoder.sv
source/mem_word_packer.sv
source/host_reply_tx.sv
source/uart_dma_top.sv
tb/tb_uart_dma.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_uart_dma -f files.f -Mdir obj_dir -o sim_uart_dma
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_uart_dma)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: source/host_cmd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module host_cmd_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                rx_data,
    input  logic                      rx_strobe,
    input  logic                      tx_busy,
    output logic                      pack_start,   // New transfer, target and addr valid
    output uart_dma_pkg::mem_target_e pack_target,
    output logic [15:0]               base_addr,
    output logic                      pack_strobe,
    output logic [7:0]                pack_byte,
    output logic                      pack_last,    // Final payload byte
    output logic                      reply_strobe,
    output uart_dma_pkg::reply_kind_e reply_kind,
    output logic                      start_execution
);

    import uart_dma_pkg::*;

    // ==================================================
    // Protocol states
    // ==================================================
    localparam logic [2:0] IDLE    = 3'd0;
    localparam logic [2:0] ADDR_HI = 3'd1;
    localparam logic [2:0] ADDR_LO = 3'd2;
    localparam logic [2:0] LEN_HI  = 3'd3;
    localparam logic [2:0] LEN_LO  = 3'd4;
    localparam logic [2:0] PAYLOAD = 3'd5;

    logic [2:0]  state;
    mem_target_e cmd_target;  // Target of the command being parsed
    logic [15:0] hdr_addr;    // Address still arriving
    logic [15:0] length;
    logic [15:0] count;       // Payload bytes taken so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= IDLE;
            cmd_target      <= TGT_UB;
            hdr_addr        <= '0;
            length          <= '0;
            count           <= '0;
            pack_target     <= TGT_UB;
            base_addr       <= '0;
            pack_byte       <= '0;
            reply_kind      <= RPL_ERROR;
            pack_start      <= 1'b0;
            pack_strobe     <= 1'b0;
            pack_last       <= 1'b0;
            reply_strobe    <= 1'b0;
            start_execution <= 1'b0;
        end else begin
            // Strobes last one cycle
            pack_start      <= 1'b0;
            pack_strobe     <= 1'b0;
            pack_last       <= 1'b0;
            reply_strobe    <= 1'b0;
            start_execution <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    IDLE: begin
                        if (!tx_busy) begin  // Command dropped while a reply is going out
                            case (rx_data)
                                CMD_WRITE_UB: begin
                                    cmd_target <= TGT_UB;
                                    state      <= ADDR_HI;
                                end
                                CMD_WRITE_WT: begin
                                    cmd_target <= TGT_WT;
                                    state      <= ADDR_HI;
                                end
                                CMD_WRITE_INSTR: begin
                                    cmd_target <= TGT_INSTR;
                                    state      <= ADDR_HI;
                                end
                                CMD_EXECUTE: start_execution <= 1'b1;
                                CMD_STATUS: begin
                                    reply_strobe <= 1'b1;
                                    reply_kind   <= RPL_STATUS;
                                end
                                default: begin  // Unknown code
                                    reply_strobe <= 1'b1;
                                    reply_kind   <= RPL_ERROR;
                                end
                            endcase
                        end
                    end
                    ADDR_HI: begin
                        hdr_addr[15:8] <= rx_data;  // Big-endian header
                        state          <= ADDR_LO;
                    end
                    ADDR_LO: begin
                        hdr_addr[7:0] <= rx_data;
                        if (cmd_target == TGT_INSTR) begin
                            // No length field, always one 32-bit word
                            length      <= 16'd4;
                            count       <= '0;
                            pack_start  <= 1'b1;
                            pack_target <= cmd_target;
                            base_addr   <= {hdr_addr[15:8], rx_data};
                            state       <= PAYLOAD;
                        end else begin
                            state <= LEN_HI;
                        end
                    end
                    LEN_HI: begin
                        length[15:8] <= rx_data;
                        state        <= LEN_LO;
                    end
                    LEN_LO: begin
                        // Zero length behaves as one byte
                        length      <= ({length[15:8], rx_data} == 16'd0) ?
                                       16'd1 : {length[15:8], rx_data};
                        count       <= '0;
                        pack_start  <= 1'b1;
                        pack_target <= cmd_target;
                        base_addr   <= hdr_addr;
                        state       <= PAYLOAD;
                    end
                    PAYLOAD: begin
                        pack_strobe <= 1'b1;
                        pack_byte   <= rx_data;
                        count       <= count + 16'd1;
                        if (count + 16'd1 == length) begin
                            pack_last <= 1'b1;
                            state     <= IDLE;
                            // Instruction writes are silent
                            if (cmd_target != TGT_INSTR) begin
                                reply_strobe <= 1'b1;
                                reply_kind   <= (cmd_target == TGT_UB) ? RPL_UB_ACK : RPL_WT_ACK;
                            end
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/host_reply_tx.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_dma_cfg.svh"

module host_reply_tx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reply_strobe,
    input  uart_dma_pkg::reply_kind_e reply_kind,
    input  logic                      sys_busy,
    input  logic                      sys_done,
    input  logic                      vpu_busy,
    input  logic                      vpu_done,
    input  logic                      ub_busy,
    input  logic                      ub_done,
    input  logic                      halt_req,
    output logic                      uart_tx,   // Serial line to host
    output logic                      tx_busy    // Frame in flight
);

    import uart_dma_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    logic [7:0]    reply_byte;
    logic [8:0]    frame;    // Data bits then stop bit, LSB goes next
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;  // 0 start, 1..8 data, 9 stop

    // ==================================================
    // Reply byte select
    // ==================================================
    always_comb begin
        case (reply_kind)
            RPL_UB_ACK: reply_byte = `REPLY_UB_ACK;
            RPL_WT_ACK: reply_byte = `REPLY_WT_ACK;
            RPL_ERROR:  reply_byte = `REPLY_ERROR;
            default:    reply_byte = {halt_req, 1'b0, ub_done, ub_busy,
                                      vpu_done, vpu_busy, sys_done, sys_busy};
        endcase
    end

    // ==================================================
    // Serializer
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            uart_tx <= 1'b1;  // Line idles high
            tx_busy <= 1'b0;
            frame   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (reply_strobe) begin
                uart_tx <= 1'b0;  // Start bit right away
                tx_busy <= 1'b1;
                frame   <= {1'b1, reply_byte};
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == CW'(CPB - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;  // Stop bit done
            end else begin
                uart_tx <= frame[0];
                frame   <= {1'b1, frame[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_word_packer.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_dma_cfg.svh"

module mem_word_packer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pack_start,
    input  uart_dma_pkg::mem_target_e     pack_target,
    input  logic [15:0]                   base_addr,
    input  logic                          pack_strobe,
    input  logic [7:0]                    pack_byte,
    input  logic                          pack_last,
    output logic                          ub_wr_en,
    output logic [`UB_ADDR_W-1:0]         ub_wr_addr,
    output logic [`UB_ADDR_W-1:0]         ub_wr_count,
    output logic [`UB_DATA_W-1:0]         ub_wr_data,
    output logic                          wt_wr_en,
    output logic [`WT_ADDR_W-1:0]         wt_wr_addr,
    output logic [`WT_DATA_W-1:0]         wt_wr_data,
    output logic                          instr_wr_en,
    output logic [`INSTR_ADDR_W-1:0]      instr_wr_addr,
    output logic [`INSTR_DATA_W-1:0]      instr_wr_data
);

    import uart_dma_pkg::*;

    localparam int UA = `UB_ADDR_W;
    localparam int LW = $clog2(`UB_DATA_W / 8);  // Lane index width

    logic [`UB_DATA_W-1:0] asm_word;   // Shared assembly register
    logic [`UB_DATA_W-1:0] next_word;  // asm_word with this byte merged
    logic [LW-1:0]         lane;
    logic [LW-1:0]         last_lane;
    logic [`WT_ADDR_W-1:0] word_cnt;   // Words written this command
    logic                  word_done;

    assign ub_wr_count = UA'(1);  // Always single-word bursts

    // ==================================================
    // Byte placement per target
    // ==================================================
    always_comb begin
        next_word = asm_word;
        if (pack_target == TGT_INSTR)
            next_word = {asm_word[`UB_DATA_W-9:0], pack_byte};  // Big-endian shift
        else
            next_word[{lane, 3'b000} +: 8] = pack_byte;         // Byte k in lane k
        case (pack_target)
            TGT_UB:  last_lane = LW'(`UB_DATA_W / 8 - 1);
            TGT_WT:  last_lane = LW'(`WT_DATA_W / 8 - 1);
            default: last_lane = LW'(`INSTR_DATA_W / 8 - 1);
        endcase
    end

    assign word_done = (lane == last_lane) || pack_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ub_wr_en    <= 1'b0;
            wt_wr_en    <= 1'b0;
            instr_wr_en <= 1'b0;
            lane        <= '0;
            word_cnt    <= '0;
        end else begin
            ub_wr_en    <= 1'b0;
            wt_wr_en    <= 1'b0;
            instr_wr_en <= 1'b0;
            if (pack_start) begin
                lane     <= '0;
                word_cnt <= '0;
            end else if (pack_strobe) begin
                if (word_done) begin
                    lane        <= '0;
                    word_cnt    <= word_cnt + 1'b1;
                    ub_wr_en    <= (pack_target == TGT_UB);
                    wt_wr_en    <= (pack_target == TGT_WT);
                    instr_wr_en <= (pack_target == TGT_INSTR);
                end else begin
                    lane <= lane + 1'b1;
                end
            end
        end
    end

    // Datapath, unused lanes stay zero
    always_ff @(posedge clk) begin
        if (pack_start)
            asm_word <= '0;
        else if (pack_strobe)
            asm_word <= word_done ? '0 : next_word;
        if (pack_strobe && word_done) begin
            ub_wr_addr    <= base_addr[UA-1:0] + word_cnt[UA-1:0];  // {bank bit, low byte}
            ub_wr_data    <= next_word;
            wt_wr_addr    <= base_addr[`WT_ADDR_W-1:0] + word_cnt;  // Wraps in 10 bits
            wt_wr_data    <= next_word[`WT_DATA_W-1:0];
            instr_wr_addr <= base_addr[`INSTR_ADDR_W-1:0];
            instr_wr_data <= next_word[`INSTR_DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: source/uart_byte_rx.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_dma_cfg.svh"

module uart_byte_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_rx,    // Serial line from host
    output logic [7:0] rx_data,    // Valid with rx_strobe
    output logic       rx_strobe   // One cycle per good byte
);

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    // FSM encoding
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [2:0]    line_sync;  // [1] synced line, [2] one cycle older
    logic          line;
    logic          fall;
    logic [1:0]    state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;

    assign line = line_sync[1];
    assign fall = line_sync[2] & ~line_sync[1];  // Start bit edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_sync <= 3'b111;  // Idle line is high
            state     <= S_IDLE;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            line_sync <= {line_sync[1:0], uart_rx};
            rx_strobe <= 1'b0;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (fall) state <= S_START;
                end
                S_START: begin
                    if (clk_cnt == CW'(CPB / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= line ? S_IDLE : S_DATA;  // Glitch goes back to idle
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (clk_cnt == CW'(CPB - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= S_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin  // S_STOP
                    if (clk_cnt == CW'(CPB - 1)) begin
                        rx_strobe <= line;  // Low stop bit drops the byte
                        state     <= S_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first, shifted in at each data bit center
    always_ff @(posedge clk) begin
        if (state == S_DATA && clk_cnt == CW'(CPB - 1))
            rx_data <= {line, rx_data[7:1]};
    end

endmodule

`default_nettype wire

// File: source/uart_dma_cfg.svh
`ifndef UART_DMA_CFG_SVH
`define UART_DMA_CFG_SVH

// ==================================================
// Serial link
// ==================================================
`define UART_CLOCK_FREQ    50_000_000
`define UART_BAUD_RATE     3_125_000
`define UART_CLKS_PER_BIT  (`UART_CLOCK_FREQ / `UART_BAUD_RATE)  // 16 here

// Memory geometry
`define UB_ADDR_W          9
`define UB_DATA_W          256   // 32 byte lanes
`define WT_ADDR_W          10
`define WT_DATA_W          64    // 8 byte lanes
`define INSTR_ADDR_W       5
`define INSTR_DATA_W       32

// Reply bytes back to host
`define REPLY_UB_ACK       8'hAA
`define REPLY_WT_ACK       8'hBB
`define REPLY_ERROR        8'hFF

`endif

// File: source/uart_dma_pkg.sv
`default_nettype none

package uart_dma_pkg;

    // ==================================================
    // Host command bytes
    // ==================================================
    typedef enum logic [7:0] {
        CMD_WRITE_UB    = 8'h01,  // Addr + len + payload
        CMD_WRITE_WT    = 8'h02,  // Addr + len + payload
        CMD_WRITE_INSTR = 8'h03,  // Addr + 4 bytes
        CMD_EXECUTE     = 8'h05,
        CMD_STATUS      = 8'h06
    } host_cmd_e;

    // Which memory the payload lands in
    typedef enum logic [1:0] {
        TGT_UB,
        TGT_WT,
        TGT_INSTR
    } mem_target_e;

    // Reply byte selector for the transmitter
    typedef enum logic [1:0] {
        RPL_UB_ACK,
        RPL_WT_ACK,
        RPL_ERROR,
        RPL_STATUS   // Live status inputs
    } reply_kind_e;

endpackage

`default_nettype wire

// File: source/uart_dma_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_dma_cfg.svh"

module uart_dma_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     uart_rx,
    output logic                     uart_tx,
    // Unified buffer
    output logic                     ub_wr_en,
    output logic [`UB_ADDR_W-1:0]    ub_wr_addr,
    output logic [`UB_ADDR_W-1:0]    ub_wr_count,
    output logic [`UB_DATA_W-1:0]    ub_wr_data,
    // Weight memory
    output logic                     wt_wr_en,
    output logic [`WT_ADDR_W-1:0]    wt_wr_addr,
    output logic [`WT_DATA_W-1:0]    wt_wr_data,
    // Instruction buffer
    output logic                     instr_wr_en,
    output logic [`INSTR_ADDR_W-1:0] instr_wr_addr,
    output logic [`INSTR_DATA_W-1:0] instr_wr_data,
    output logic                     start_execution,
    // Status from the datapath
    input  logic                     sys_busy,
    input  logic                     sys_done,
    input  logic                     vpu_busy,
    input  logic                     vpu_done,
    input  logic                     ub_busy,
    input  logic                     ub_done,
    input  logic                     halt_req
);

    import uart_dma_pkg::*;

    logic [7:0]  rx_data;
    logic        rx_strobe;
    logic        tx_busy;
    logic        pack_start;
    mem_target_e pack_target;
    logic [15:0] base_addr;
    logic        pack_strobe;
    logic [7:0]  pack_byte;
    logic        pack_last;
    logic        reply_strobe;
    reply_kind_e reply_kind;

    // ==================================================
    // Receive, decode, pack, reply
    // ==================================================
    uart_byte_rx rx0 (
        .clk, .rst, .uart_rx,
        .rx_data, .rx_strobe
    );

    host_cmd_decoder dec0 (
        .clk, .rst, .rx_data, .rx_strobe, .tx_busy,
        .pack_start, .pack_target, .base_addr,
        .pack_strobe, .pack_byte, .pack_last,
        .reply_strobe, .reply_kind, .start_execution
    );

    mem_word_packer pack0 (
        .clk, .rst, .pack_start, .pack_target, .base_addr,
        .pack_strobe, .pack_byte, .pack_last,
        .ub_wr_en, .ub_wr_addr, .ub_wr_count, .ub_wr_data,
        .wt_wr_en, .wt_wr_addr, .wt_wr_data,
        .instr_wr_en, .instr_wr_addr, .instr_wr_data
    );

    host_reply_tx reply0 (
        .clk, .rst, .reply_strobe, .reply_kind,
        .sys_busy, .sys_done, .vpu_busy, .vpu_done,
        .ub_busy, .ub_done, .halt_req,
        .uart_tx, .tx_busy
    );

endmodule

`default_nettype wire

// File: tb/tb_uart_dma.sv
`timescale 1ns/10ps
`default_nettype none
`include "uart_dma_cfg.svh"

module tb_uart_dma;

    import uart_dma_pkg::*;

    localparam int CPB        = `UART_CLKS_PER_BIT;
    localparam int NROWS      = 10;
    localparam int MAXB       = 48;
    localparam int WAIT_LIMIT = 20 * CPB;  // Cycles before a wait gives up
    localparam int SETTLE     = 12 * CPB;  // Quiet time after a row, longer than one frame

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     uart_rx;
    logic                     uart_tx;
    logic                     ub_wr_en;
    logic [`UB_ADDR_W-1:0]    ub_wr_addr;
    logic [`UB_ADDR_W-1:0]    ub_wr_count;
    logic [`UB_DATA_W-1:0]    ub_wr_data;
    logic                     wt_wr_en;
    logic [`WT_ADDR_W-1:0]    wt_wr_addr;
    logic [`WT_DATA_W-1:0]    wt_wr_data;
    logic                     instr_wr_en;
    logic [`INSTR_ADDR_W-1:0] instr_wr_addr;
    logic [`INSTR_DATA_W-1:0] instr_wr_data;
    logic                     start_execution;
    logic                     sys_busy;
    logic                     sys_done;
    logic                     vpu_busy;
    logic                     vpu_done;
    logic                     ub_busy;
    logic                     ub_done;
    logic                     halt_req;

    // ==================================================
    // Stimulus and expectation table
    // ==================================================
    logic [7:0]   row_bytes  [NROWS][MAXB];  // Bytes on the serial line
    int           row_len    [NROWS];
    bit           row_bad    [NROWS];        // First byte sent with a low stop bit
    // {halt, ub_done, ub_busy, vpu_done, vpu_busy, sys_done, sys_busy}
    logic [6:0]   row_status [NROWS];
    int           row_reply  [NROWS];        // -1 when no reply is due
    int           row_starts [NROWS];        // start_execution pulses
    int           row_nwr    [NROWS];        // Memory writes, at most two
    mem_target_e  exp_tgt    [NROWS][2];
    logic [9:0]   exp_addr   [NROWS][2];
    logic [255:0] exp_data   [NROWS][2];
    logic [7:0]   pay        [64];           // Payload of the row being built

    // Observed traffic
    mem_target_e  wr_tgt_q  [$];
    logic [9:0]   wr_addr_q [$];
    logic [255:0] wr_data_q [$];
    logic [7:0]   reply_q   [$];
    int           start_cnt;
    int           exp_starts;

    logic         mon_busy;
    int           mon_cnt;   // Cycles into the reply frame
    logic [7:0]   mon_byte;

    always #10 clk = ~clk;  // 50 MHz

    uart_dma_top dut0 (
        .clk, .rst, .uart_rx, .uart_tx,
        .ub_wr_en, .ub_wr_addr, .ub_wr_count, .ub_wr_data,
        .wt_wr_en, .wt_wr_addr, .wt_wr_data,
        .instr_wr_en, .instr_wr_addr, .instr_wr_data,
        .start_execution,
        .sys_busy, .sys_done, .vpu_busy, .vpu_done,
        .ub_busy, .ub_done, .halt_req
    );

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // ==================================================
    // Monitors
    // ==================================================
    always @(posedge clk) begin
        if (rst) begin
            start_cnt <= 0;
        end else begin
            if (start_execution) start_cnt <= start_cnt + 1;
            if (ub_wr_en) begin
                assert (ub_wr_count == 9'd1)
                    else report_error($sformatf("ub_wr_count %0d, expected 1", ub_wr_count));
                wr_tgt_q.push_back(TGT_UB);
                wr_addr_q.push_back(10'(ub_wr_addr));
                wr_data_q.push_back(ub_wr_data);
            end else if (wt_wr_en) begin
                wr_tgt_q.push_back(TGT_WT);
                wr_addr_q.push_back(wt_wr_addr);
                wr_data_q.push_back({192'b0, wt_wr_data});
            end else if (instr_wr_en) begin
                wr_tgt_q.push_back(TGT_INSTR);
                wr_addr_q.push_back(10'(instr_wr_addr));
                wr_data_q.push_back({224'b0, instr_wr_data});
            end
        end
    end

    // Reply line decoder, samples each bit at its center
    always @(posedge clk) begin
        if (rst) begin
            mon_busy <= 1'b0;
            mon_cnt  <= 0;
        end else if (!mon_busy) begin
            if (!uart_tx) begin  // Start bit seen
                mon_busy <= 1'b1;
                mon_cnt  <= 1;
            end
        end else begin
            mon_cnt <= mon_cnt + 1;
            if (mon_cnt % CPB == CPB / 2) begin
                if (mon_cnt / CPB == 0) begin
                    assert (!uart_tx) else report_error("reply start bit did not stay low");
                end else if (mon_cnt / CPB <= 8) begin
                    mon_byte <= {uart_tx, mon_byte[7:1]};  // LSB first
                end else begin
                    assert (uart_tx) else report_error("reply frame has a low stop bit");
                    reply_q.push_back(mon_byte);
                    mon_busy <= 1'b0;
                end
            end
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [255:0] lanes_lsb_first(input int first, input int n);
        logic [255:0] word;
        int k;
        word = '0;
        for (k = n - 1; k >= 0; k--)
            word = {word[247:0], pay[first + k]};  // First byte lands in lane 0
        return word;
    endfunction

    // Status reply layout, bit 6 always reads zero
    function automatic logic [7:0] status_reply(input logic [6:0] s);
        return {s[6], 1'b0, s[5:0]};
    endfunction

    function automatic bit arrived(input int which);
        case (which)
            0:       return wr_tgt_q.size() != 0;
            1:       return reply_q.size() != 0;
            default: return start_cnt >= exp_starts;
        endcase
    endfunction

    task automatic wait_for(input int which, input string what);
        int t;
        t = 0;
        while (!arrived(which) && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        assert (arrived(which)) else report_error({"timed out waiting for ", what});
    endtask

    task automatic send_byte(input logic [7:0] b, input bit good_stop);
        logic [9:0] frame;
        frame = {good_stop, b, 1'b0};  // Stop, data, start
        repeat (10) begin
            @(posedge clk);
            uart_rx <= frame[0];
            frame = {1'b1, frame[9:1]};
            repeat (CPB - 1) @(posedge clk);
        end
        if (!good_stop) begin  // Line back high before the next start bit
            @(posedge clk);
            uart_rx <= 1'b1;
            repeat (CPB - 1) @(posedge clk);
        end
    endtask

    task automatic add_byte(input int r, input logic [7:0] b);
        row_bytes[r][row_len[r]] = b;
        row_len[r] = row_len[r] + 1;
    endtask

    task automatic add_write(input int r, input logic [7:0] cmd, input logic [15:0] addr,
                             input int len);
        int k;
        add_byte(r, cmd);
        add_byte(r, addr[15:8]);  // Big-endian header
        add_byte(r, addr[7:0]);
        add_byte(r, 8'(len >> 8));
        add_byte(r, 8'(len));
        for (k = 0; k < len; k++) begin
            pay[k] = 8'($urandom());
            add_byte(r, pay[k]);
        end
    endtask

    task automatic expect_write(input int r, input int w, input mem_target_e tgt,
                                input logic [9:0] addr, input logic [255:0] data);
        exp_tgt[r][w]  = tgt;
        exp_addr[r][w] = addr;
        exp_data[r][w] = data;
        row_nwr[r]     = w + 1;
    endtask

    task automatic build_table();
        int r;
        int k;
        for (r = 0; r < NROWS; r++) begin
            row_len[r]    = 0;
            row_bad[r]    = 1'b0;
            row_status[r] = 7'd0;
            row_reply[r]  = -1;
            row_starts[r] = 0;
            row_nwr[r]    = 0;
        end
        // Unified buffer, one full word and one 8-byte tail
        add_write(0, 8'h01, 16'h0110, 40);
        expect_write(0, 0, TGT_UB, 10'h110, lanes_lsb_first(0, 32));
        expect_write(0, 1, TGT_UB, 10'h111, lanes_lsb_first(32, 8));
        row_reply[0] = 'hAA;
        // Weight memory, address wraps after 0x3FF
        add_write(1, 8'h02, 16'h03FF, 11);
        expect_write(1, 0, TGT_WT, 10'h3FF, lanes_lsb_first(0, 8));
        expect_write(1, 1, TGT_WT, 10'h000, lanes_lsb_first(8, 3));
        row_reply[1] = 'hBB;
        // Instruction, big-endian, no reply
        for (k = 0; k < 7; k++)
            add_byte(2, 8'(56'h03_0025_12345678 >> (8 * (6 - k))));
        expect_write(2, 0, TGT_INSTR, 10'd5, 256'h12345678);
        add_byte(3, 8'h05);
        row_starts[3] = 1;
        add_byte(4, 8'h06);
        row_status[4] = 7'b0011001;  // ub_busy, vpu_done, sys_busy
        row_reply[4]  = int'(status_reply(row_status[4]));
        add_byte(5, 8'h06);
        row_status[5] = 7'b1100110;  // halt_req, ub_done, vpu_busy, sys_done
        row_reply[5]  = int'(status_reply(row_status[5]));
        add_byte(6, 8'h04);
        row_reply[6] = 'hFF;
        add_byte(7, 8'h14);
        row_reply[7] = 'hFF;
        add_byte(8, 8'h7E);
        row_reply[8] = 'hFF;
        // Corrupted write command, then a status request
        add_byte(9, 8'h01);
        row_bad[9] = 1'b1;
        add_byte(9, 8'h06);
        row_status[9] = 7'b0110011;
        row_reply[9]  = int'(status_reply(row_status[9]));
    endtask

    task automatic check_write(input int r, input int w);
        wait_for(0, "a memory write strobe");
        assert (wr_tgt_q[0] == exp_tgt[r][w] && wr_addr_q[0] == exp_addr[r][w]
                && wr_data_q[0] == exp_data[r][w])
            else report_error($sformatf(
                "row %0d write %0d: target %0d addr %h data %h, expected %0d %h %h",
                r, w, wr_tgt_q[0], wr_addr_q[0], wr_data_q[0],
                exp_tgt[r][w], exp_addr[r][w], exp_data[r][w]));
        void'(wr_tgt_q.pop_front());
        void'(wr_addr_q.pop_front());
        void'(wr_data_q.pop_front());
    endtask

    task automatic check_reply(input int r);
        wait_for(1, "a reply byte on uart_tx");
        assert (reply_q[0] == row_reply[r][7:0])
            else report_error($sformatf("row %0d: reply %h, expected %h",
                                        r, reply_q[0], row_reply[r][7:0]));
        void'(reply_q.pop_front());
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int r;
        int i;
        int w;
        void'($urandom(32'h33be54b4));
        rst        = 1'b1;
        uart_rx    = 1'b1;  // Idle line
        {halt_req, ub_done, ub_busy, vpu_done, vpu_busy, sys_done, sys_busy} = 7'd0;
        exp_starts = 0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(negedge clk);
        for (r = 0; r < NROWS; r++) begin
            @(posedge clk);
            {halt_req, ub_done, ub_busy, vpu_done, vpu_busy, sys_done, sys_busy} <= row_status[r];
            exp_starts = exp_starts + row_starts[r];
            for (i = 0; i < row_len[r]; i++)
                send_byte(row_bytes[r][i], !(row_bad[r] && i == 0));
            for (w = 0; w < row_nwr[r]; w++)
                check_write(r, w);
            if (row_reply[r] >= 0)
                check_reply(r);
            wait_for(2, "a start_execution pulse");
            repeat (SETTLE) @(negedge clk);  // Catch late or extra traffic
            assert (wr_tgt_q.size() == 0)
                else report_error($sformatf("row %0d: unexpected memory write", r));
            assert (reply_q.size() == 0)
                else report_error($sformatf("row %0d: unexpected reply byte", r));
            assert (start_cnt == exp_starts)
                else report_error($sformatf("row %0d: %0d start pulses, expected %0d",
                                            r, start_cnt, exp_starts));
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
